/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
TOP       := spi_master_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST OK" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
verilog/spi_pkg.sv
verilog/spi_tx_fifo.sv
verilog/spi_master_regs.sv
verilog/spi_master_io.sv
verilog/spi_master.sv
tb/spi_slave_model.sv
tb/spi_master_tb.sv

/* tb/spi_master_tb.sv */
//################################################
// SPI master testbench
// table of packet operations against an echoing
// slave model, with checks and a watchdog
//################################################

module spi_master_tb;

   localparam int MAX_ROWS   = 96;
   localparam int N_TX       = 12;     // bytes sent over the whole run
   localparam int POLL_LIMIT = 4096;   // status reads per wait row

   typedef enum logic [2:0]
   {
      OP_WRITE,      // register write
      OP_READ,       // register read, compare data
      OP_WAIT_RX,    // poll STATUS until bit 0
      OP_CHK_WAIT,   // compare wait_out level
      OP_CHK_SS      // compare count of ss_n falls
   } op_kind_e;

   logic                 clk = 1'b0;
   logic                 nreset;
   logic                 hw_en;
   logic                 access_in;
   spi_pkg::spi_packet_t packet_in;
   logic                 wait_out;
   logic                 access_out;
   spi_pkg::spi_packet_t packet_out;
   logic                 wait_in;
   logic                 sclk;
   logic                 mosi;
   logic                 ss_n;
   logic                 miso;
   logic                 slave_cpol;
   logic                 slave_cpha;
   logic                 slave_lsb;
   int                   slave_errors;

   op_kind_e    row_kind [MAX_ROWS];
   logic [5:0]  row_off  [MAX_ROWS];
   logic [31:0] row_data [MAX_ROWS];
   logic [31:0] row_exp  [MAX_ROWS];
   int          n_rows = 0;
   logic [7:0]  tx_bytes [N_TX];
   logic [63:0] model_win  = '0;       // expected rx window
   logic [7:0]  model_last = '0;       // byte the slave holds for echo
   int          model_ss   = 0;        // expected ss_n falls
   int          seed       = 32'h2ba24b68;
   int          n_checks   = 0;
   int          n_errors   = 0;
   int          n_reads    = 0;
   int          ss_falls   = 0;
   bit          table_ready = 1'b0;

   always #2 clk = ~clk;

   always @(negedge ss_n)
      ss_falls = ss_falls + 1;

   spi_master u_dut
   (
      .clk        (clk),
      .nreset     (nreset),
      .hw_en      (hw_en),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in),
      .sclk       (sclk),
      .mosi       (mosi),
      .ss_n       (ss_n),
      .miso       (miso)
   );

   spi_slave_model u_slave
   (
      .sclk        (sclk),
      .mosi        (mosi),
      .ss_n        (ss_n),
      .cpol        (slave_cpol),
      .cpha        (slave_cpha),
      .lsbfirst    (slave_lsb),
      .miso        (miso),
      .mode_errors (slave_errors)
   );

   //################################################
   // checking and bus access
   //################################################
   task check_value(input string name, input logic [63:0] actual, input logic [63:0] expected);
      n_checks++;
      if (actual !== expected)
      begin
         n_errors++;
         $display("MISMATCH %s: actual 0x%0h expected 0x%0h at %0t",
                  name, actual, expected, $time);
      end
   endtask

   task drive_packet(input logic wr, input logic [5:0] off, input logic [31:0] data,
                     input logic [31:0] src);
      spi_pkg::spi_packet_t pkt;
      pkt          = '0;
      pkt.write    = wr;
      pkt.datamode = src[6:5];          // varies per read and must come back
      pkt.ctrlmode = src[4:0];
      pkt.dstaddr  = {26'h0, off};
      pkt.srcaddr  = src;
      pkt.data     = data;
      @(posedge clk);
      access_in <= 1'b1;
      packet_in <= pkt;
      @(posedge clk);
      access_in <= 1'b0;
   endtask

   task write_reg(input logic [5:0] off, input logic [31:0] data);
      drive_packet(1'b1, off, data, 32'h0);
   endtask

   task read_reg(input logic [5:0] off, output logic [31:0] value);
      logic [31:0] src;
      n_reads++;
      src = 32'h0000_A000 + 32'(n_reads);
      drive_packet(1'b0, off, 32'h0, src);
      @(negedge clk);                   // one cycle after the request edge
      check_value("access_out", 64'(access_out), 64'd1);
      check_value("packet_out.dstaddr", 64'(packet_out.dstaddr), 64'(src));
      check_value("packet_out.srcaddr", 64'(packet_out.srcaddr), 64'd0);
      check_value("packet_out.write", 64'(packet_out.write), 64'd1);
      check_value("packet_out.ctrlmode", 64'(packet_out.ctrlmode), 64'(src[4:0]));
      check_value("packet_out.datamode", 64'(packet_out.datamode), 64'(src[6:5]));
      value = packet_out.data;
   endtask

   task wait_rx_flag;
      logic [31:0] status;
      int          polls;
      status = '0;
      polls  = 0;
      while ((status[0] !== 1'b1) && (polls < POLL_LIMIT))
      begin
         read_reg(spi_pkg::SPI_STATUS, status);
         polls++;
      end
      if (status[0] !== 1'b1)
      begin
         n_errors++;
         $display("rx flag in STATUS still clear after %0d polls", polls);
      end
   endtask

   //################################################
   // operation table
   //################################################
   task add_row(input op_kind_e kind, input logic [5:0] off, input logic [31:0] data,
                input logic [31:0] expected);
      row_kind[n_rows] = kind;
      row_off[n_rows]  = off;
      row_data[n_rows] = data;
      row_exp[n_rows]  = expected;
      n_rows++;
   endtask

   task add_tx(input logic [7:0] value);
      add_row(OP_WRITE, spi_pkg::SPI_TX, 32'(value), 32'h0);
      model_win  = {model_win[55:0], model_last};   // slave returns its previous byte
      model_last = value;
      model_ss++;
   endtask

   task add_transfer(input logic [7:0] value, input bit show_status);
      add_tx(value);
      add_row(OP_WAIT_RX, 6'h0, 32'h0, 32'h0);
      if (show_status)
         add_row(OP_READ, spi_pkg::SPI_STATUS, 32'h0, 32'h1);   // only the rx flag
      add_row(OP_WRITE, spi_pkg::SPI_STATUS, 32'h0, 32'h0);    // clear rx flag
      if (show_status)
         add_row(OP_READ, spi_pkg::SPI_STATUS, 32'h0, 32'h0);
   endtask

   task build_table;
      logic [31:0] rnd;
      logic [7:0]  modes [4];
      int          i;
      int          ss_before;
      modes = '{8'h1C, 8'h1C, 8'h04, 8'h08};          // cpol/cpha/lsbfirst mixes
      for (i = 0; i < N_TX; i++)
      begin
         rnd         = $random(seed);
         tx_bytes[i] = rnd[7:0];
      end
      // reset values
      add_row(OP_READ, spi_pkg::SPI_CONFIG, 32'h0, 32'h0);
      add_row(OP_READ, spi_pkg::SPI_CLKDIV, 32'h0, 32'h1);
      add_row(OP_READ, spi_pkg::SPI_STATUS, 32'h0, 32'h0);
      // readback of low byte, unmapped and write-only offsets
      add_row(OP_WRITE, spi_pkg::SPI_CONFIG, 32'h5A5A_0012, 32'h0);
      add_row(OP_READ, spi_pkg::SPI_CONFIG, 32'h0, 32'h12);
      add_row(OP_WRITE, spi_pkg::SPI_CLKDIV, 32'hABCD_0125, 32'h0);
      add_row(OP_READ, spi_pkg::SPI_CLKDIV, 32'h0, 32'h25);
      add_row(OP_WRITE, spi_pkg::SPI_CMD, 32'h1, 32'h0);
      add_row(OP_READ, spi_pkg::SPI_CMD, 32'h0, 32'hDEADBEEF);
      add_row(OP_READ, spi_pkg::SPI_TX, 32'h0, 32'hDEADBEEF);
      add_row(OP_READ, 6'h05, 32'h0, 32'hDEADBEEF);
      add_row(OP_READ, 6'h3F, 32'h0, 32'hDEADBEEF);
      // mode 0 msb first with status flag set and clear
      add_row(OP_WRITE, spi_pkg::SPI_CLKDIV, 32'h1, 32'h0);
      add_row(OP_WRITE, spi_pkg::SPI_CONFIG, 32'h0, 32'h0);
      add_transfer(tx_bytes[0], 1'b1);
      add_transfer(tx_bytes[1], 1'b1);
      add_row(OP_READ, spi_pkg::SPI_RX0, 32'h0, model_win[31:0]);
      // other clock modes and bit order
      add_row(OP_WRITE, spi_pkg::SPI_CLKDIV, 32'h2, 32'h0);
      for (i = 0; i < 4; i++)
      begin
         add_row(OP_WRITE, spi_pkg::SPI_CONFIG, 32'(modes[i]), 32'h0);
         add_transfer(tx_bytes[2 + i], 1'b0);
      end
      add_row(OP_READ, spi_pkg::SPI_RX0, 32'h0, model_win[31:0]);
      add_row(OP_READ, spi_pkg::SPI_RX1, 32'h0, model_win[63:32]);
      // back-pressure with spi disabled
      add_row(OP_WRITE, spi_pkg::SPI_CLKDIV, 32'h1, 32'h0);
      add_row(OP_WRITE, spi_pkg::SPI_CONFIG, 32'h1, 32'h0);
      ss_before = model_ss;
      for (i = 6; i < N_TX; i++)
         add_tx(tx_bytes[i]);
      add_row(OP_CHK_WAIT, 6'h0, 32'h0, 32'h1);
      add_row(OP_READ, spi_pkg::SPI_STATUS, 32'h0, 32'h4);       // prog_full only
      add_row(OP_CHK_SS, 6'h0, 32'h0, 32'(ss_before));           // nothing sent yet
      add_row(OP_WRITE, spi_pkg::SPI_CONFIG, 32'h0, 32'h0);
      for (i = 6; i < N_TX; i++)
      begin
         add_row(OP_WAIT_RX, 6'h0, 32'h0, 32'h0);
         add_row(OP_WRITE, spi_pkg::SPI_STATUS, 32'h0, 32'h0);
      end
      add_row(OP_CHK_WAIT, 6'h0, 32'h0, 32'h0);
      add_row(OP_CHK_SS, 6'h0, 32'h0, 32'(model_ss));
      add_row(OP_READ, spi_pkg::SPI_RX0, 32'h0, model_win[31:0]);
      add_row(OP_READ, spi_pkg::SPI_RX1, 32'h0, model_win[63:32]);
      add_row(OP_READ, spi_pkg::SPI_STATUS, 32'h0, 32'h0);
   endtask

   task apply_row(input int r);
      logic [31:0] value;
      case (row_kind[r])
         OP_WRITE :
         begin
            if (row_off[r] == spi_pkg::SPI_CONFIG)
            begin
               slave_cpol <= row_data[r][2];      // slave follows the bus mode
               slave_cpha <= row_data[r][3];
               slave_lsb  <= row_data[r][4];
            end
            write_reg(row_off[r], row_data[r]);
         end
         OP_READ :
         begin
            read_reg(row_off[r], value);
            check_value($sformatf("packet_out.data[off %02h]", row_off[r]),
                        64'(value), 64'(row_exp[r]));
         end
         OP_WAIT_RX :
            wait_rx_flag();
         OP_CHK_WAIT :
         begin
            @(negedge clk);
            check_value("wait_out", 64'(wait_out), 64'(row_exp[r]));
         end
         OP_CHK_SS :
         begin
            @(negedge clk);
            check_value("ss_n falls", 64'(ss_falls), 64'(row_exp[r]));
         end
         default : ;
      endcase
   endtask

   //################################################
   // main sequence and watchdog
   //################################################
   initial
   begin
      int r;
      nreset     = 1'b0;
      hw_en      = 1'b1;
      access_in  = 1'b0;
      packet_in  = '0;
      wait_in    = 1'b0;
      slave_cpol = 1'b0;
      slave_cpha = 1'b0;
      slave_lsb  = 1'b0;
      build_table();
      table_ready = 1'b1;
      repeat (10) @(posedge clk);
      nreset <= 1'b1;
      for (r = 0; r < n_rows; r++)
         apply_row(r);
      check_value("slave mode errors", 64'(slave_errors), 64'd0);
      $display("checks %0d errors %0d rows %0d", n_checks, n_errors, n_rows);
      if (n_errors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

   initial
   begin
      longint limit;
      wait (table_ready);
      limit = longint'(n_rows) * longint'(20 * 2 * 256 * 4);   // worst divider per row
      #(limit);
      $display("timeout: %0d table rows not finished after %0d time units", n_rows, limit);
      $display("TEST FAILED");
      $finish;
   end

endmodule

/* tb/spi_slave_model.sv */
//################################################
// SPI slave model for the testbench
// 8-bit shift register, echoes the byte that it
// received in the previous transfer
//################################################

module spi_slave_model
(
   input  logic sclk,
   input  logic mosi,
   input  logic ss_n,
   input  logic cpol,          // idle level of sclk
   input  logic cpha,          // 1 = sample on second edge
   input  logic lsbfirst,      // bit order
   output logic miso,
   output int   mode_errors    // sclk off its idle level at ss_n edges
);

   logic [7:0] tx_reg    = 8'h00;   // byte going out on miso
   logic [7:0] rx_reg    = 8'h00;   // byte coming in on mosi
   logic [7:0] last_byte = 8'h00;   // sent back next transfer
   logic       ss_prev   = 1'b1;
   logic       sclk_prev = 1'b0;
   logic       in_xfer   = 1'b0;
   logic       skip_lead = 1'b0;    // cpha 1, first edge moves nothing
   int         err_cnt   = 0;

   assign miso        = lsbfirst ? tx_reg[0] : tx_reg[7];
   assign mode_errors = err_cnt;

   task sample_mosi;
      rx_reg = lsbfirst ? {mosi, rx_reg[7:1]} : {rx_reg[6:0], mosi};
   endtask

   task shift_miso;
      tx_reg = lsbfirst ? {1'b0, tx_reg[7:1]} : {tx_reg[6:0], 1'b0};
   endtask

   //################################################
   // select and clock edges
   //################################################
   always @(ss_n or sclk)
   begin
      if ((ss_n === 1'b0) && (ss_prev === 1'b1))
      begin
         if (sclk !== cpol)
         begin
            err_cnt = err_cnt + 1;
            $display("slave: sclk is not at its idle level when ss_n falls at %0t", $time);
         end
         tx_reg    = last_byte;            // echo byte, first bit at once
         skip_lead = cpha;
         in_xfer   = 1'b1;
      end
      else if ((ss_n === 1'b1) && in_xfer)
      begin
         if (sclk !== cpol)
         begin
            err_cnt = err_cnt + 1;
            $display("slave: sclk is not at its idle level when ss_n rises at %0t", $time);
         end
         last_byte = rx_reg;
         in_xfer   = 1'b0;
      end
      else if ((ss_n === 1'b0) && (sclk !== sclk_prev))
      begin
         if (sclk !== cpol)                // leading edge
         begin
            if (!cpha)
               sample_mosi();
            else if (skip_lead)
               skip_lead = 1'b0;
            else
               shift_miso();
         end
         else if (!cpha)                   // trailing edge
            shift_miso();
         else
            sample_mosi();
      end
      ss_prev   = ss_n;
      sclk_prev = sclk;
   end

endmodule

/* verilog/spi_master.sv */
//################################################
// SPI master top level
// register block and tx fifo feed the shift engine
//################################################

module spi_master
(
   input  logic                 clk,
   input  logic                 nreset,
   input  logic                 hw_en,       // block enable pin
   // core packet interface
   input  logic                 access_in,
   input  spi_pkg::spi_packet_t packet_in,
   output logic                 wait_out,    // tx fifo back-pressure
   output logic                 access_out,  // read response
   output spi_pkg::spi_packet_t packet_out,
   input  logic                 wait_in,     // reads are never stalled
   // spi pins
   output logic                 sclk,
   output logic                 mosi,
   output logic                 ss_n,
   input  logic                 miso
);

   spi_pkg::spi_cfg_t   cfg;
   spi_pkg::spi_state_e spi_state;
   logic                tx_push;
   logic [7:0]          tx_byte;
   logic                tx_pop;
   logic [7:0]          rd_byte;
   logic                not_empty;
   logic                prog_full;
   logic                rx_access;
   logic [63:0]         rx_data;

   assign wait_out = prog_full;

   //################################################
   // registers
   //################################################
   spi_master_regs u_regs
   (
      .clk        (clk),
      .nreset     (nreset),
      .hw_en      (hw_en),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .rx_access  (rx_access),
      .rx_data    (rx_data),
      .spi_state  (spi_state),
      .prog_full  (prog_full),
      .cfg        (cfg),
      .tx_push    (tx_push),
      .tx_byte    (tx_byte),
      .access_out (access_out),
      .packet_out (packet_out)
   );

   // tx byte buffer
   spi_tx_fifo u_fifo
   (
      .clk       (clk),
      .nreset    (nreset),
      .tx_push   (tx_push),
      .tx_byte   (tx_byte),
      .tx_pop    (tx_pop),
      .rd_byte   (rd_byte),
      .not_empty (not_empty),
      .prog_full (prog_full)
   );

   //################################################
   // shift engine
   //################################################
   spi_master_io u_io
   (
      .clk       (clk),
      .nreset    (nreset),
      .cfg       (cfg),
      .not_empty (not_empty),
      .rd_byte   (rd_byte),
      .tx_pop    (tx_pop),
      .spi_state (spi_state),
      .rx_access (rx_access),
      .rx_data   (rx_data),
      .sclk      (sclk),
      .mosi      (mosi),
      .ss_n      (ss_n),
      .miso      (miso)
   );

endmodule

/* verilog/spi_master_io.sv */
//################################################
// SPI master shift engine
// sclk divider, byte FSM, mosi/miso shifting and
// the 64-bit rx window
//################################################

module spi_master_io
(
   input  logic                clk,
   input  logic                nreset,
   input  spi_pkg::spi_cfg_t   cfg,
   input  logic                not_empty,   // fifo has a byte
   input  logic [7:0]          rd_byte,     // fifo head
   output logic                tx_pop,      // byte taken
   output spi_pkg::spi_state_e spi_state,
   output logic                rx_access,   // byte finished
   output logic [63:0]         rx_data,     // newest byte in 7:0
   output logic                sclk,
   output logic                mosi,
   output logic                ss_n,
   input  logic                miso
);

   logic [7:0] div_cnt;      // half period counter
   logic [3:0] edge_cnt;     // sclk edges done in DATA
   logic [7:0] tx_shift;
   logic [7:0] rx_shift;
   logic       tick;         // end of a half period / phase
   logic       data_tick;
   logic       lead_edge;    // first edge of a bit
   logic       trail_edge;   // second edge of a bit
   logic       sample;
   logic       shift_out;

   //################################################
   // divider
   //################################################
   assign tick = (spi_state != spi_pkg::IDLE) & (div_cnt == cfg.clkdiv);

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         div_cnt <= 8'd0;
      else if ((spi_state == spi_pkg::IDLE) || tick)
         div_cnt <= 8'd0;
      else
         div_cnt <= div_cnt + 8'd1;
   end

   //################################################
   // edge decode
   //################################################
   assign data_tick  = tick & (spi_state == spi_pkg::DATA);
   assign lead_edge  = data_tick & ~edge_cnt[0];
   assign trail_edge = data_tick & edge_cnt[0];

   // cpha 0: sample first, change second
   // cpha 1: change first (not the very first edge), sample second
   assign sample    = cfg.cpha ? trail_edge : lead_edge;
   assign shift_out = cfg.cpha ? (lead_edge & (edge_cnt != 4'd0)) : trail_edge;

   assign tx_pop = (spi_state == spi_pkg::IDLE) & cfg.spi_en & not_empty;

   //################################################
   // transfer FSM
   //################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         spi_state <= spi_pkg::IDLE;
         edge_cnt  <= 4'd0;
         sclk      <= 1'b0;
         ss_n      <= 1'b1;
         rx_access <= 1'b0;
         rx_data   <= 64'd0;
      end
      else
      begin
         rx_access <= 1'b0;
         case (spi_state)
            spi_pkg::IDLE :
            begin
               sclk     <= cfg.cpol;         // park at idle level
               edge_cnt <= 4'd0;
               if (tx_pop)
               begin
                  ss_n      <= 1'b0;
                  spi_state <= spi_pkg::SETUP;
               end
            end
            spi_pkg::SETUP :
               if (tick)
                  spi_state <= spi_pkg::DATA;
            spi_pkg::DATA :
               if (data_tick)
               begin
                  sclk     <= ~sclk;
                  edge_cnt <= edge_cnt + 4'd1;
                  if (edge_cnt == 4'd15)      // 16th edge, back at cpol
                     spi_state <= spi_pkg::HOLD;
               end
            spi_pkg::HOLD :
               if (tick)
               begin
                  ss_n      <= 1'b1;
                  rx_access <= 1'b1;
                  rx_data   <= {rx_data[55:0], rx_shift}; // append newest
                  spi_state <= spi_pkg::IDLE;
               end
            default : spi_state <= spi_pkg::IDLE;
         endcase
      end
   end

   //################################################
   // shift registers
   //################################################
   always_ff @(posedge clk)
   begin
      if (tx_pop)
         tx_shift <= rd_byte;              // first bit shows at once
      else if (shift_out)
         tx_shift <= cfg.lsbfirst ? {1'b0, tx_shift[7:1]} : {tx_shift[6:0], 1'b0};
      if (sample)
         rx_shift <= cfg.lsbfirst ? {miso, rx_shift[7:1]} : {rx_shift[6:0], miso};
   end

   assign mosi = cfg.lsbfirst ? tx_shift[0] : tx_shift[7];

   a_ss_active: assert property (@(posedge clk) disable iff (!nreset)
      (spi_state != spi_pkg::IDLE) |-> !ss_n);

endmodule

/* verilog/spi_master_regs.sv */
//################################################
// SPI master register block
// decodes core packets, holds config/status/clkdiv,
// captures the rx window and returns read packets
//################################################

module spi_master_regs
(
   input  logic                clk,
   input  logic                nreset,
   input  logic                hw_en,        // block enable pin
   input  logic                access_in,    // core access strobe
   input  spi_pkg::spi_packet_t packet_in,
   input  logic                rx_access,    // byte done pulse
   input  logic [63:0]         rx_data,      // shifted rx window
   input  spi_pkg::spi_state_e spi_state,    // engine state
   input  logic                prog_full,    // fifo nearly full
   output spi_pkg::spi_cfg_t   cfg,          // to shift engine
   output logic                tx_push,      // fifo push strobe
   output logic [7:0]          tx_byte,      // fifo push data
   output logic                access_out,   // read response strobe
   output spi_pkg::spi_packet_t packet_out
);

   logic                      reg_write;
   logic                      reg_read;
   spi_pkg::spi_reg_e         reg_offset;
   logic [7:0]                config_reg;
   logic [7:0]                status_reg;
   logic [7:0]                clkdiv_reg;
   logic [63:0]               rx_reg;
   logic [spi_pkg::AW-1:0]    reg_rdata;
   logic [spi_pkg::AW-1:0]    dstaddr_out;
   logic [4:0]                ctrlmode_out;
   logic [1:0]                datamode_out;
   logic [spi_pkg::PW-1:0]    resp_vec;

   //################################################
   // decode
   //################################################
   assign reg_write  = access_in & packet_in.write;
   assign reg_read   = access_in & ~packet_in.write;
   assign reg_offset = spi_pkg::spi_reg_e'(packet_in.dstaddr[5:0]);

   // tx writes go straight to the fifo
   assign tx_push = reg_write & (reg_offset == spi_pkg::SPI_TX);
   assign tx_byte = packet_in.data[7:0];

   //################################################
   // config / clkdiv
   //################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         config_reg <= 8'h00;                  // spi on by default
         clkdiv_reg <= spi_pkg::CLKDIV_RESET;
      end
      else if (reg_write)
      begin
         if (reg_offset == spi_pkg::SPI_CONFIG)
            config_reg <= packet_in.data[7:0];
         if (reg_offset == spi_pkg::SPI_CLKDIV)
            clkdiv_reg <= packet_in.data[7:0];
      end
   end

   // bit 1 (irq enable) is kept for readback only
   assign cfg.spi_en   = hw_en & ~config_reg[0];
   assign cfg.cpol     = config_reg[2];
   assign cfg.cpha     = config_reg[3];
   assign cfg.lsbfirst = config_reg[4];
   assign cfg.clkdiv   = clkdiv_reg;

   //################################################
   // status
   //################################################
   // a write loads for one cycle and live bits take over after
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         status_reg <= 8'h00;
      else if (reg_write && (reg_offset == spi_pkg::SPI_STATUS))
         status_reg <= packet_in.data[7:0];
      else
         status_reg <= {5'b0,
                        prog_full,                       // 2
                        spi_state != spi_pkg::IDLE,      // 1 busy
                        rx_access | status_reg[0]};      // 0 sticky
   end

   // rx window snapshot at end of each byte
   always_ff @(posedge clk)
   begin
      if (rx_access)
         rx_reg <= rx_data;
   end

   //################################################
   // readback
   //################################################
   always_ff @(posedge clk)
   begin
      if (reg_read)
      begin
         case (reg_offset)
            spi_pkg::SPI_CONFIG : reg_rdata <= {24'b0, config_reg};
            spi_pkg::SPI_STATUS : reg_rdata <= {24'b0, status_reg};
            spi_pkg::SPI_CLKDIV : reg_rdata <= {24'b0, clkdiv_reg};
            spi_pkg::SPI_RX0    : reg_rdata <= rx_reg[31:0];
            spi_pkg::SPI_RX1    : reg_rdata <= rx_reg[63:32];
            default             : reg_rdata <= 32'hDEADBEEF; // cmd, tx, holes
         endcase
         dstaddr_out  <= packet_in.srcaddr;   // reply goes back to sender
         ctrlmode_out <= packet_in.ctrlmode;
         datamode_out <= packet_in.datamode;
      end
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         access_out <= 1'b0;
      else
         access_out <= reg_read;
   end

   // response packet with write=1 and srcaddr=0
   assign resp_vec   = {1'b1, datamode_out, ctrlmode_out, dstaddr_out,
                        {spi_pkg::AW{1'b0}}, reg_rdata};
   assign packet_out = resp_vec;

   // decode needs a known direction and offset
   a_access_known: assert property (@(posedge clk) disable iff (!nreset)
      access_in |-> !$isunknown({packet_in.write, packet_in.dstaddr[5:0]}));

endmodule

/* verilog/spi_pkg.sv */
//################################################
// SPI master shared definitions
// packet layout, register map, engine states, sizes
//################################################

package spi_pkg;

   //################################################
   // sizes
   //################################################
   localparam int AW = 32;                    // packet address/data width
   localparam int PW = 8 + 3 * AW;            // packet width, 104

   localparam logic [7:0] CLKDIV_RESET = 8'd1; // divider after reset

   localparam int FIFO_DEPTH = 8;             // tx fifo entries (power of two)
   localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

   typedef logic [FIFO_AW-1:0] fifo_ptr_t;    // read/write pointers
   typedef logic [FIFO_AW:0]   fifo_cnt_t;    // occupancy, one extra bit for full

   localparam fifo_cnt_t FIFO_PROG_FULL = fifo_cnt_t'(6); // wait threshold

   //################################################
   // packet
   //################################################
   // msb first, same order as on the core bus
   typedef struct packed
   {
      logic          write;     // 1 = write, 0 = read
      logic [1:0]    datamode;  // access size
      logic [4:0]    ctrlmode;  // passed back on reads
      logic [AW-1:0] dstaddr;   // register offset in bits 5:0
      logic [AW-1:0] srcaddr;   // return address for reads
      logic [AW-1:0] data;      // write data / read data
   } spi_packet_t;

   //################################################
   // register map, dstaddr[5:0]
   //################################################
   typedef enum logic [5:0]
   {
      SPI_CONFIG = 6'h00,   // cfg bits, see below
      SPI_STATUS = 6'h01,   // rx flag, busy, prog_full
      SPI_CLKDIV = 6'h02,   // half-period divider
      SPI_CMD    = 6'h03,   // write only, accepted and ignored
      SPI_TX     = 6'h08,   // write only, pushes byte to fifo
      SPI_RX0    = 6'h10,   // rx window low word
      SPI_RX1    = 6'h11    // rx window high word
   } spi_reg_e;

   // config bits
   // 0 spi disable, 1 irq enable, 2 cpol, 3 cpha, 4 lsbfirst

   //################################################
   // shift engine
   //################################################
   typedef enum logic [1:0]
   {
      IDLE  = 2'd0,   // waiting on fifo
      SETUP = 2'd1,   // ss_n low, first bit on mosi
      DATA  = 2'd2,   // 16 sclk half periods
      HOLD  = 2'd3    // ss_n hold before release
   } spi_state_e;

   // register block to engine
   typedef struct packed
   {
      logic       spi_en;     // hw_en and not disabled
      logic       cpol;       // sclk idle level
      logic       cpha;       // sample on second edge
      logic       lsbfirst;   // bit order
      logic [7:0] clkdiv;     // half period = clkdiv+1 cycles
   } spi_cfg_t;

endpackage

/* verilog/spi_tx_fifo.sv */
//################################################
// SPI transmit FIFO
// small byte buffer between tx writes and engine
//################################################

module spi_tx_fifo
(
   input  logic       clk,
   input  logic       nreset,
   input  logic       tx_push,     // write strobe from regs
   input  logic [7:0] tx_byte,
   input  logic       tx_pop,      // engine took head byte
   output logic [7:0] rd_byte,     // head entry
   output logic       not_empty,
   output logic       prog_full    // drives wait_out
);

   logic [7:0]         mem [spi_pkg::FIFO_DEPTH];
   spi_pkg::fifo_ptr_t wr_ptr;
   spi_pkg::fifo_ptr_t rd_ptr;
   spi_pkg::fifo_cnt_t count;
   logic               full;
   logic               do_push;
   logic               do_pop;

   assign full    = count[spi_pkg::FIFO_AW];   // count == depth
   assign do_push = tx_push & ~full;           // push into full fifo is lost
   assign do_pop  = tx_pop & not_empty;

   //################################################
   // storage
   //################################################
   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= tx_byte;
   end

   assign rd_byte = mem[rd_ptr];

   //################################################
   // pointers and fill level
   //################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;     // wraps at depth
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10   : count <= count + 1'b1;
            2'b01   : count <= count - 1'b1;
            default : count <= count;    // none, or both at once
         endcase
      end
   end

   assign not_empty = (count != '0);
   assign prog_full = (count >= spi_pkg::FIFO_PROG_FULL);

   // core has to honour wait_out
   a_no_push_full: assert property (@(posedge clk) disable iff (!nreset)
      tx_push |-> !full);

   a_no_pop_empty: assert property (@(posedge clk) disable iff (!nreset)
      tx_pop |-> not_empty);

endmodule
